//--- arp_pkg.sv
// Shared types and constants for the ARP transmit path.
// IPv4 over Ethernet II only, no VLAN tag; frame sizes exclude the FCS.
package arp_pkg;

    // field widths with a meaning of their own
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] ethertype_t;
    typedef logic [15:0] arp_oper_t;
    typedef logic [7:0]  byte_t;

    // Ethernet and ARP constants
    localparam ethertype_t ETH_TYPE_ARP     = 16'h0806;
    localparam ethertype_t ARP_HTYPE_ETH    = 16'h0001;
    localparam ethertype_t ARP_PTYPE_IPV4   = 16'h0800;
    localparam arp_oper_t  ARP_OPER_REQUEST = 16'h0001;
    localparam arp_oper_t  ARP_OPER_REPLY   = 16'h0002;
    localparam byte_t      ARP_HLEN         = 8'd6;
    localparam byte_t      ARP_PLEN         = 8'd4;
    localparam mac_addr_t  MAC_BROADCAST    = '1;

    // frame layout in bytes
    localparam int ETH_HDR_BYTES       = 14;
    localparam int ARP_BODY_BYTES      = 28;
    localparam int ETH_MIN_FRAME_BYTES = 60;

    // ARP body serializer
    typedef enum logic {
        IDLE,
        WRITE
    } tx_state_t;

    // frame output sequencer, DONE doubles as the wait for a header
    typedef enum logic [1:0] {
        HDR,
        PAYLOAD,
        PAD,
        DONE
    } out_state_t;

endpackage

//--- arp_req_decode.sv
// Turns one ARP command into the Ethernet header and ARP body fields.
// Holds a single command; the next one is taken only after the frame
// is handed on. local_mac and local_ip are sampled on acceptance.
`timescale 1ns/100ps

module arp_req_decode (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  logic                cmd_is_reply,
    input  arp_pkg::mac_addr_t  cmd_target_mac,
    input  arp_pkg::ip_addr_t   cmd_target_ip,
    input  arp_pkg::mac_addr_t  local_mac,
    input  arp_pkg::ip_addr_t   local_ip,
    output logic                frame_valid,
    input  logic                frame_ready,
    output arp_pkg::mac_addr_t  eth_dest_mac,
    output arp_pkg::mac_addr_t  eth_src_mac,
    output arp_pkg::ethertype_t eth_type,
    output arp_pkg::ethertype_t arp_htype,
    output arp_pkg::ethertype_t arp_ptype,
    output arp_pkg::arp_oper_t  arp_oper,
    output arp_pkg::mac_addr_t  arp_sha,
    output arp_pkg::ip_addr_t   arp_spa,
    output arp_pkg::mac_addr_t  arp_tha,
    output arp_pkg::ip_addr_t   arp_tpa
);
    import arp_pkg::*;

    logic      ready_q;
    logic      cmd_fire;
    mac_addr_t dest_q;
    mac_addr_t sha_q;
    mac_addr_t tha_q;
    ip_addr_t  spa_q;
    ip_addr_t  tpa_q;
    arp_oper_t oper_q;

    // ready_q keeps cmd_ready low for one cycle after reset
    assign cmd_ready = ready_q & ~frame_valid;
    assign cmd_fire  = cmd_valid & cmd_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_q     <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            ready_q <= 1'b1;
            if (cmd_fire) begin
                frame_valid <= 1'b1;
            end else if (frame_ready) begin
                frame_valid <= 1'b0;
            end
        end
    end

    // request goes to broadcast with unknown THA, reply back to the asker
    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            dest_q <= cmd_is_reply ? cmd_target_mac : MAC_BROADCAST;
            tha_q  <= cmd_is_reply ? cmd_target_mac : '0;
            oper_q <= cmd_is_reply ? ARP_OPER_REPLY : ARP_OPER_REQUEST;
            sha_q  <= local_mac;
            spa_q  <= local_ip;
            tpa_q  <= cmd_target_ip;
        end
    end

    assign eth_dest_mac = dest_q;
    assign eth_src_mac  = sha_q;
    assign eth_type     = ETH_TYPE_ARP;
    assign arp_htype    = ARP_HTYPE_ETH;
    assign arp_ptype    = ARP_PTYPE_IPV4;
    assign arp_oper     = oper_q;
    assign arp_sha      = sha_q;
    assign arp_spa      = spa_q;
    assign arp_tha      = tha_q;
    assign arp_tpa      = tpa_q;

    // a stalled frame must not change under the serializer
    a_fields_stable: assert property (@(posedge clk) disable iff (rst)
        frame_valid && !frame_ready |=> $stable({dest_q, sha_q, spa_q, tha_q, tpa_q, oper_q}));

endmodule

//--- arp_eth_tx.sv
// Serializes one ARP body of 28 bytes, most significant byte first.
// The header fields leave on their own valid/ready link; a new frame
// is accepted only once the previous header has been taken.
// The payload output is a two-entry skid buffer with a registered ready.
`timescale 1ns/100ps

module arp_eth_tx (
    input  logic                clk,
    input  logic                rst,
    input  logic                frame_valid,
    output logic                frame_ready,
    input  arp_pkg::mac_addr_t  eth_dest_mac,
    input  arp_pkg::mac_addr_t  eth_src_mac,
    input  arp_pkg::ethertype_t eth_type,
    input  arp_pkg::ethertype_t arp_htype,
    input  arp_pkg::ethertype_t arp_ptype,
    input  arp_pkg::arp_oper_t  arp_oper,
    input  arp_pkg::mac_addr_t  arp_sha,
    input  arp_pkg::ip_addr_t   arp_spa,
    input  arp_pkg::mac_addr_t  arp_tha,
    input  arp_pkg::ip_addr_t   arp_tpa,
    output logic                hdr_valid,
    input  logic                hdr_ready,
    output arp_pkg::mac_addr_t  hdr_dest_mac,
    output arp_pkg::mac_addr_t  hdr_src_mac,
    output arp_pkg::ethertype_t hdr_type,
    output arp_pkg::byte_t      pay_data,
    output logic                pay_valid,
    input  logic                pay_ready,
    output logic                pay_last,
    output logic                busy
);
    import arp_pkg::*;

    tx_state_t  state;
    tx_state_t  state_next;
    logic [4:0] ptr;
    logic [4:0] ptr_next;
    logic       store_frame;
    logic       frame_ready_next;
    logic       hdr_valid_next;

    ethertype_t htype_q;
    ethertype_t ptype_q;
    arp_oper_t  oper_q;
    mac_addr_t  sha_q;
    mac_addr_t  tha_q;
    ip_addr_t   spa_q;
    ip_addr_t   tpa_q;

    logic [8*ARP_BODY_BYTES-1:0] body_vec;
    logic [8*ARP_BODY_BYTES-1:0] body_shift;

    // byte stream into the skid buffer
    byte_t data_int;
    logic  valid_int;
    logic  last_int;
    logic  ready_int;
    logic  ready_int_early;

    // skid buffer spare entry and load enables
    byte_t temp_data;
    logic  temp_valid;
    logic  temp_last;
    logic  load_out_int;
    logic  load_temp;
    logic  load_out_temp;

    // body in wire order, HLEN and PLEN are fixed
    assign body_vec   = {htype_q, ptype_q, ARP_HLEN, ARP_PLEN, oper_q,
                         sha_q, spa_q, tha_q, tpa_q};
    assign body_shift = body_vec << (8 * ptr);

    always_comb begin
        state_next       = state;
        ptr_next         = ptr;
        store_frame      = 1'b0;
        frame_ready_next = 1'b0;
        hdr_valid_next   = hdr_valid & ~hdr_ready;
        data_int         = '0;
        valid_int        = 1'b0;
        last_int         = 1'b0;

        case (state)
            IDLE: begin
                ptr_next         = '0;
                frame_ready_next = ~hdr_valid;
                if (frame_valid && frame_ready) begin
                    store_frame      = 1'b1;
                    frame_ready_next = 1'b0;
                    hdr_valid_next   = 1'b1;
                    state_next       = WRITE;
                    // first byte straight from the inputs, saves a cycle
                    if (ready_int) begin
                        data_int  = arp_htype[15:8];
                        valid_int = 1'b1;
                        ptr_next  = 5'd1;
                    end
                end
            end
            WRITE: begin
                if (ready_int) begin
                    data_int  = body_shift[8*ARP_BODY_BYTES-1 -: 8];
                    valid_int = 1'b1;
                    ptr_next  = ptr + 5'd1;
                    if (ptr == 5'(ARP_BODY_BYTES - 1)) begin
                        last_int         = 1'b1;
                        frame_ready_next = ~hdr_valid;
                        state_next       = IDLE;
                    end
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            ptr         <= '0;
            frame_ready <= 1'b0;
            hdr_valid   <= 1'b0;
            busy        <= 1'b0;
        end else begin
            state       <= state_next;
            ptr         <= ptr_next;
            frame_ready <= frame_ready_next;
            hdr_valid   <= hdr_valid_next;
            busy        <= (state_next != IDLE) | hdr_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_frame) begin
            hdr_dest_mac <= eth_dest_mac;
            hdr_src_mac  <= eth_src_mac;
            hdr_type     <= eth_type;
            htype_q      <= arp_htype;
            ptype_q      <= arp_ptype;
            oper_q       <= arp_oper;
            sha_q        <= arp_sha;
            spa_q        <= arp_spa;
            tha_q        <= arp_tha;
            tpa_q        <= arp_tpa;
        end
    end

    // ready for next cycle if the sink takes a byte or an entry stays free
    assign ready_int_early = pay_ready | (~temp_valid & ~pay_valid)
                           | (~temp_valid & ~valid_int);

    assign load_out_int  = ready_int & (pay_ready | ~pay_valid);
    assign load_temp     = ready_int & ~pay_ready & pay_valid;
    assign load_out_temp = ~ready_int & pay_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_int  <= 1'b0;
            pay_valid  <= 1'b0;
            pay_last   <= 1'b0;
            temp_valid <= 1'b0;
            temp_last  <= 1'b0;
        end else begin
            ready_int <= ready_int_early;
            if (load_out_int) begin
                pay_valid <= valid_int;
                pay_last  <= last_int;
            end else if (load_temp) begin
                temp_valid <= valid_int;
                temp_last  <= last_int;
            end else if (load_out_temp) begin
                pay_valid  <= temp_valid;
                pay_last   <= temp_last;
                temp_valid <= 1'b0;
                temp_last  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_out_int) begin
            pay_data <= data_int;
        end else if (load_temp) begin
            temp_data <= data_int;
        end else if (load_out_temp) begin
            pay_data <= temp_data;
        end
    end

    a_last_valid: assert property (@(posedge clk) disable iff (rst)
        pay_last |-> pay_valid);

endmodule

//--- eth_frame_out.sv
// Builds the Ethernet frame: 14 header bytes, the ARP payload as it
// arrives, then zero padding up to the 60-byte minimum (FCS not included).
// The payload is expected to be exactly 28 bytes with pay_last on the last.
`timescale 1ns/100ps

module eth_frame_out (
    input  logic                clk,
    input  logic                rst,
    input  logic                hdr_valid,
    output logic                hdr_ready,
    input  arp_pkg::mac_addr_t  hdr_dest_mac,
    input  arp_pkg::mac_addr_t  hdr_src_mac,
    input  arp_pkg::ethertype_t hdr_type,
    input  arp_pkg::byte_t      pay_data,
    input  logic                pay_valid,
    output logic                pay_ready,
    input  logic                pay_last,
    output arp_pkg::byte_t      out_data,
    output logic                out_valid,
    input  logic                out_ready,
    output logic                out_last,
    output logic                busy
);
    import arp_pkg::*;

    out_state_t state;
    logic [5:0] count;
    logic       out_fire;

    logic [8*ETH_HDR_BYTES-1:0] hdr_q;
    logic [8*ETH_HDR_BYTES-1:0] hdr_shift;

    assign hdr_shift = hdr_q << (8 * count);
    assign hdr_ready = (state == DONE);
    assign pay_ready = (state == PAYLOAD) & out_ready;
    assign busy      = (state != DONE);
    assign out_fire  = out_valid & out_ready;

    always_comb begin
        out_data  = '0;
        out_valid = 1'b0;
        out_last  = 1'b0;
        case (state)
            HDR: begin
                out_data  = hdr_shift[8*ETH_HDR_BYTES-1 -: 8];
                out_valid = 1'b1;
            end
            // straight pass-through, the serializer's skid buffer holds the data
            PAYLOAD: begin
                out_data  = pay_data;
                out_valid = pay_valid;
            end
            PAD: begin
                out_valid = 1'b1;
                out_last  = (count == 6'(ETH_MIN_FRAME_BYTES - 1));
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= DONE;
            count <= '0;
        end else begin
            case (state)
                DONE: begin
                    if (hdr_valid) begin
                        state <= HDR;
                        count <= '0;
                    end
                end
                HDR: begin
                    if (out_fire) begin
                        count <= count + 6'd1;
                        if (count == 6'(ETH_HDR_BYTES - 1)) begin
                            state <= PAYLOAD;
                        end
                    end
                end
                PAYLOAD: begin
                    if (out_fire) begin
                        count <= count + 6'd1;
                        if (pay_last) begin
                            state <= PAD;
                        end
                    end
                end
                PAD: begin
                    if (out_fire) begin
                        count <= out_last ? '0 : count + 6'd1;
                        if (out_last) begin
                            state <= DONE;
                        end
                    end
                end
                default: state <= DONE;
            endcase
        end
    end

    // header captured in the same transfer that takes it
    always_ff @(posedge clk) begin
        if (hdr_valid && hdr_ready) begin
            hdr_q <= {hdr_dest_mac, hdr_src_mac, hdr_type};
        end
    end

    // serializer and frame counter must agree on the body length
    a_last_at_41: assert property (@(posedge clk) disable iff (rst)
        (state == PAYLOAD && pay_valid && pay_ready) |->
            (pay_last == (count == 6'(ETH_HDR_BYTES + ARP_BODY_BYTES - 1))));

endmodule

//--- arp_tx_top.sv
// ARP transmit path: command decode, body serializer, frame output.
// One frame can wait in decode while another is being sent.
// Output is a byte stream of 60-byte frames without FCS.
`timescale 1ns/100ps

module arp_tx_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               cmd_valid,
    output logic               cmd_ready,
    input  logic               cmd_is_reply,
    input  arp_pkg::mac_addr_t cmd_target_mac,
    input  arp_pkg::ip_addr_t  cmd_target_ip,
    input  arp_pkg::mac_addr_t local_mac,
    input  arp_pkg::ip_addr_t  local_ip,
    output arp_pkg::byte_t     out_data,
    output logic               out_valid,
    input  logic               out_ready,
    output logic               out_last,
    output logic               busy
);
    import arp_pkg::*;

    // frame link
    logic       frame_valid;
    logic       frame_ready;
    mac_addr_t  eth_dest_mac;
    mac_addr_t  eth_src_mac;
    ethertype_t eth_type;
    ethertype_t arp_htype;
    ethertype_t arp_ptype;
    arp_oper_t  arp_oper;
    mac_addr_t  arp_sha;
    ip_addr_t   arp_spa;
    mac_addr_t  arp_tha;
    ip_addr_t   arp_tpa;

    // header and payload links
    logic       hdr_valid;
    logic       hdr_ready;
    mac_addr_t  hdr_dest_mac;
    mac_addr_t  hdr_src_mac;
    ethertype_t hdr_type;
    byte_t      pay_data;
    logic       pay_valid;
    logic       pay_ready;
    logic       pay_last;

    logic       tx_busy;
    logic       out_busy;

    assign busy = tx_busy | out_busy;

    arp_req_decode u_decode (
        .clk            (clk),
        .rst            (rst),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .cmd_is_reply   (cmd_is_reply),
        .cmd_target_mac (cmd_target_mac),
        .cmd_target_ip  (cmd_target_ip),
        .local_mac      (local_mac),
        .local_ip       (local_ip),
        .frame_valid    (frame_valid),
        .frame_ready    (frame_ready),
        .eth_dest_mac   (eth_dest_mac),
        .eth_src_mac    (eth_src_mac),
        .eth_type       (eth_type),
        .arp_htype      (arp_htype),
        .arp_ptype      (arp_ptype),
        .arp_oper       (arp_oper),
        .arp_sha        (arp_sha),
        .arp_spa        (arp_spa),
        .arp_tha        (arp_tha),
        .arp_tpa        (arp_tpa)
    );

    arp_eth_tx u_arp_eth_tx (
        .clk          (clk),
        .rst          (rst),
        .frame_valid  (frame_valid),
        .frame_ready  (frame_ready),
        .eth_dest_mac (eth_dest_mac),
        .eth_src_mac  (eth_src_mac),
        .eth_type     (eth_type),
        .arp_htype    (arp_htype),
        .arp_ptype    (arp_ptype),
        .arp_oper     (arp_oper),
        .arp_sha      (arp_sha),
        .arp_spa      (arp_spa),
        .arp_tha      (arp_tha),
        .arp_tpa      (arp_tpa),
        .hdr_valid    (hdr_valid),
        .hdr_ready    (hdr_ready),
        .hdr_dest_mac (hdr_dest_mac),
        .hdr_src_mac  (hdr_src_mac),
        .hdr_type     (hdr_type),
        .pay_data     (pay_data),
        .pay_valid    (pay_valid),
        .pay_ready    (pay_ready),
        .pay_last     (pay_last),
        .busy         (tx_busy)
    );

    eth_frame_out u_frame_out (
        .clk          (clk),
        .rst          (rst),
        .hdr_valid    (hdr_valid),
        .hdr_ready    (hdr_ready),
        .hdr_dest_mac (hdr_dest_mac),
        .hdr_src_mac  (hdr_src_mac),
        .hdr_type     (hdr_type),
        .pay_data     (pay_data),
        .pay_valid    (pay_valid),
        .pay_ready    (pay_ready),
        .pay_last     (pay_last),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_last     (out_last),
        .busy         (out_busy)
    );

endmodule

//--- tb_arp_tx.sv
// Testbench for the ARP transmit path: 40 random requests and replies,
// random back-pressure on the output and a byte-by-byte frame model.
// Stops at the first mismatch; a watchdog bounds the run time.
`timescale 1ns/100ps

module tb_arp_tx;
    import arp_pkg::*;

    localparam int NUM_CMDS     = 40;
    localparam int FRAME_BYTES  = 60;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    // four cycles per byte at worst plus reset and drain
    localparam int WATCHDOG_CYCLES = NUM_CMDS * FRAME_BYTES * 4 + 1000;

    typedef struct packed {
        logic      is_reply;
        mac_addr_t target_mac;
        ip_addr_t  target_ip;
        mac_addr_t local_mac;
        ip_addr_t  local_ip;
    } cmd_t;

    logic      clk;
    logic      rst;
    logic      cmd_valid;
    logic      cmd_ready;
    logic      cmd_is_reply;
    mac_addr_t cmd_target_mac;
    ip_addr_t  cmd_target_ip;
    mac_addr_t local_mac;
    ip_addr_t  local_ip;
    byte_t     out_data;
    logic      out_valid;
    logic      out_ready = 1'b0;
    logic      out_last;
    logic      busy;

    cmd_t  cmd_list[NUM_CMDS];
    cmd_t  pending_q[$];
    cmd_t  accepted_cmd;
    cmd_t  head_cmd;
    byte_t exp_byte;
    int    byte_idx    = 0;
    int    frames_done = 0;
    int    stall_left  = 0;
    int    cycle_count = 0;
    logic  rst_q       = 1'b0;
    logic  held_valid  = 1'b0;
    byte_t held_data   = '0;
    logic  held_last   = 1'b0;

    arp_tx_top u_arp_tx_top (
        .clk            (clk),
        .rst            (rst),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .cmd_is_reply   (cmd_is_reply),
        .cmd_target_mac (cmd_target_mac),
        .cmd_target_ip  (cmd_target_ip),
        .local_mac      (local_mac),
        .local_ip       (local_ip),
        .out_data       (out_data),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_last       (out_last),
        .busy           (busy)
    );

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string test, input int expected, input int actual);
        stop_on_failure($sformatf("** Error %s: expected %0h, actual %0h",
                                  test, expected, actual));
    endtask

    // whole frame in wire order from the ARP and Ethernet field rules
    function automatic byte_t expected_byte(input cmd_t c, input int idx);
        logic [8*FRAME_BYTES-1:0] frame;
        logic [8*FRAME_BYTES-1:0] shifted;
        mac_addr_t                dest;
        mac_addr_t                tha;
        logic [15:0]              oper;
        dest  = c.is_reply ? c.target_mac : 48'hffff_ffff_ffff;
        tha   = c.is_reply ? c.target_mac : 48'h0;
        oper  = c.is_reply ? 16'h0002 : 16'h0001;
        frame = {dest, c.local_mac, 16'h0806,
                 16'h0001, 16'h0800, 8'h06, 8'h04, oper,
                 c.local_mac, c.local_ip, tha, c.target_ip,
                 144'h0};
        shifted = frame >> (8 * (FRAME_BYTES - 1 - idx));
        return shifted[7:0];
    endfunction

    function automatic string region_name(input cmd_t c, input int idx);
        if (idx >= 42) begin
            return "frame_padding";
        end
        return c.is_reply ? "reply_frame" : "request_frame";
    endfunction

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_on_failure($sformatf("timeout: only %0d of %0d frames seen in %0d cycles",
                                  frames_done, NUM_CMDS, WATCHDOG_CYCLES));
    end

    // mostly ready, short random drops, now and then a long stall
    always @(posedge clk) begin
        if (rst) begin
            stall_left = 0;
            out_ready <= 1'b1;
        end else if (stall_left > 0) begin
            stall_left = stall_left - 1;
            out_ready <= 1'b0;
        end else if ($urandom_range(0, 255) == 0) begin
            stall_left = int'($urandom_range(30, 70));
            out_ready <= 1'b0;
        end else begin
            out_ready <= ($urandom_range(0, 3) != 0);
        end
    end

    initial begin : driver
        logic [63:0] rnd_mac;
        logic [31:0] rnd;
        int          gap;
        int          i;
        rnd            = $urandom(16537);
        rst            = 1'b1;
        cmd_valid      = 1'b0;
        cmd_is_reply   = 1'b0;
        cmd_target_mac = '0;
        cmd_target_ip  = '0;
        local_mac      = '0;
        local_ip       = '0;
        for (i = 0; i < NUM_CMDS; i++) begin
            rnd                    = $urandom();
            cmd_list[i].is_reply   = rnd[0];
            rnd_mac                = {$urandom(), $urandom()};
            cmd_list[i].target_mac = rnd_mac[47:0];
            cmd_list[i].target_ip  = $urandom();
            rnd_mac                = {$urandom(), $urandom()};
            cmd_list[i].local_mac  = rnd_mac[47:0];
            cmd_list[i].local_ip   = $urandom();
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // mostly back to back with an idle gap every few commands
        for (i = 0; i < NUM_CMDS; i++) begin
            rnd = $urandom();
            gap = (rnd[1:0] == 2'b00) ? int'(rnd[4:2]) + 1 : 0;
            if (gap > 0) begin
                cmd_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            cmd_valid      <= 1'b1;
            cmd_is_reply   <= cmd_list[i].is_reply;
            cmd_target_mac <= cmd_list[i].target_mac;
            cmd_target_ip  <= cmd_list[i].target_ip;
            local_mac      <= cmd_list[i].local_mac;
            local_ip       <= cmd_list[i].local_ip;
            @(posedge clk);
            while (!cmd_ready) @(posedge clk);
        end
        cmd_valid <= 1'b0;

        wait (frames_done == NUM_CMDS);
        repeat (5) @(posedge clk);
        if (!busy) begin
            $display("Regression passed");
            $finish;
        end else begin
            stop_on_failure("busy still high after the last frame was sent");
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        // the edge that first applies reset is skipped
        if ((rst || rst_q) && cycle_count > 1) begin
            assert ({out_valid, busy, cmd_ready} == 3'b000)
                else report_mismatch("reset_state", 0, int'({out_valid, busy, cmd_ready}));
        end
        rst_q = rst;

        if (!rst) begin
            if (cmd_valid && cmd_ready) begin
                accepted_cmd.is_reply   = cmd_is_reply;
                accepted_cmd.target_mac = cmd_target_mac;
                accepted_cmd.target_ip  = cmd_target_ip;
                accepted_cmd.local_mac  = local_mac;
                accepted_cmd.local_ip   = local_ip;
                pending_q.push_back(accepted_cmd);
            end

            // a stalled byte stays put until it is taken
            if (held_valid) begin
                assert (out_valid)
                    else stop_on_failure("out_valid dropped while the output was stalled");
                assert ({out_last, out_data} == {held_last, held_data})
                    else report_mismatch("stall_hold", int'({held_last, held_data}),
                                         int'({out_last, out_data}));
            end
            held_valid = out_valid && !out_ready;
            held_data  = out_data;
            held_last  = out_last;

            if (out_valid && out_ready) begin
                if (pending_q.size() == 0) begin
                    stop_on_failure("output byte seen with no command pending");
                end else begin
                    head_cmd = pending_q[0];
                    exp_byte = expected_byte(head_cmd, byte_idx);
                    assert (out_data == exp_byte)
                        else report_mismatch($sformatf("%s frame %0d byte %0d",
                                             region_name(head_cmd, byte_idx),
                                             frames_done, byte_idx),
                                             int'(exp_byte), int'(out_data));
                    assert (out_last == (byte_idx == FRAME_BYTES - 1))
                        else report_mismatch($sformatf("frame_length frame %0d byte %0d",
                                             frames_done, byte_idx),
                                             int'(byte_idx == FRAME_BYTES - 1),
                                             int'(out_last));
                    if (out_last) begin
                        head_cmd    = pending_q.pop_front();
                        frames_done = frames_done + 1;
                        byte_idx    = 0;
                    end else begin
                        byte_idx = byte_idx + 1;
                    end
                end
            end
        end
    end

    a_busy_with_valid: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> busy)
        else stop_on_failure("busy was low while out_valid was high");

    a_last_with_valid: assert property (@(posedge clk) disable iff (rst)
        out_last |-> out_valid)
        else stop_on_failure("out_last was high without out_valid");

endmodule

//--- filelist.f
arp_pkg.sv
arp_req_decode.sv
arp_eth_tx.sv
eth_frame_out.sv
arp_tx_top.sv
tb_arp_tx.sv

//--- Makefile
# Verilator build and run of the ARP transmit testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_arp_tx -f filelist.f -o sim_arp_tx

run: compile
	./obj_dir/sim_arp_tx 2>&1 | tee run.log
	grep -q "^Regression passed" run.log

clean:
	rm -rf obj_dir run.log
